//--- src/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // Screen geometry.
    localparam int screen_w = 16;
    localparam int screen_h = 16;
    localparam int pix_count = screen_w * screen_h;

    // Pixel coordinate, may lie off screen before clamping.
    typedef logic signed [15:0] coord_t;

    // Edge function value.
    typedef logic signed [15:0] edge_t;

    typedef logic signed [15:0] depth_t;

    // Linear pixel address, y * screen_w + x.
    typedef logic [7:0] addr_t;

    typedef logic [7:0] color_t;

    // Value written by a clear, farther than any fragment.
    localparam depth_t depth_far = 16'h7fff;

    typedef enum logic [1:0] {
        idle,
        load,
        scan,
        finish
    } walk_state_t;

endpackage

`default_nettype wire

//--- src/triangle_setup.sv
`default_nettype none

module triangle_setup (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  raster_pkg::coord_t  x0,
    input  raster_pkg::coord_t  y0,
    input  raster_pkg::coord_t  x1,
    input  raster_pkg::coord_t  y1,
    input  raster_pkg::coord_t  x2,
    input  raster_pkg::coord_t  y2,
    input  raster_pkg::depth_t  z,
    input  raster_pkg::depth_t  dz_dx,
    input  raster_pkg::depth_t  dz_dy,
    output logic                setup_valid,
    output logic                empty,
    output raster_pkg::coord_t  box_x0,
    output raster_pkg::coord_t  box_y0,
    output raster_pkg::coord_t  box_x1,
    output raster_pkg::coord_t  box_y1,
    output raster_pkg::edge_t   edge0,
    output raster_pkg::edge_t   edge1,
    output raster_pkg::edge_t   edge2,
    output raster_pkg::edge_t   edge_dx0,
    output raster_pkg::edge_t   edge_dx1,
    output raster_pkg::edge_t   edge_dx2,
    output raster_pkg::edge_t   edge_dy0,
    output raster_pkg::edge_t   edge_dy1,
    output raster_pkg::edge_t   edge_dy2,
    output raster_pkg::depth_t  depth_start,
    output raster_pkg::depth_t  step_z_x,
    output raster_pkg::depth_t  step_z_y
);

    import raster_pkg::*;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // A box wholly off screen stays empty after clamping.
    function automatic coord_t at_least_zero(coord_t v);
        return (v < 0) ? coord_t'(0) : v;
    endfunction

    function automatic coord_t at_most(coord_t v, coord_t hi);
        return (v > hi) ? hi : v;
    endfunction

    // E = (xb - xa) * (py - ya) - (yb - ya) * (px - xa), wrapped to 16 bits.
    function automatic edge_t edge_at(coord_t xa, coord_t ya, coord_t xb, coord_t yb,
                                      coord_t px, coord_t py);
        return edge_t'((xb - xa) * (py - ya) - (yb - ya) * (px - xa));
    endfunction

    localparam coord_t x_hi = coord_t'(screen_w - 1);
    localparam coord_t y_hi = coord_t'(screen_h - 1);

    logic   s1_valid;
    coord_t r_x0, r_y0, r_x1, r_y1, r_x2, r_y2;
    coord_t r_bx0, r_by0, r_bx1, r_by1;
    depth_t r_z, r_dzx, r_dzy;

    // Stage one: capture vertices, bound and clamp.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            r_x0  <= x0;
            r_y0  <= y0;
            r_x1  <= x1;
            r_y1  <= y1;
            r_x2  <= x2;
            r_y2  <= y2;
            r_z   <= z;
            r_dzx <= dz_dx;
            r_dzy <= dz_dy;
            r_bx0 <= at_least_zero(min3(x0, x1, x2));
            r_by0 <= at_least_zero(min3(y0, y1, y2));
            r_bx1 <= at_most(max3(x0, x1, x2), x_hi);
            r_by1 <= at_most(max3(y0, y1, y2), y_hi);
        end
    end

    // Stage two: edges and depth at the box corner.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            setup_valid <= 1'b0;
        end else begin
            setup_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            box_x0      <= r_bx0;
            box_y0      <= r_by0;
            box_x1      <= r_bx1;
            box_y1      <= r_by1;
            empty       <= (r_bx0 > r_bx1) || (r_by0 > r_by1);
            edge0       <= edge_at(r_x0, r_y0, r_x1, r_y1, r_bx0, r_by0);
            edge1       <= edge_at(r_x1, r_y1, r_x2, r_y2, r_bx0, r_by0);
            edge2       <= edge_at(r_x2, r_y2, r_x0, r_y0, r_bx0, r_by0);
            edge_dx0    <= edge_t'(r_y0 - r_y1);
            edge_dx1    <= edge_t'(r_y1 - r_y2);
            edge_dx2    <= edge_t'(r_y2 - r_y0);
            edge_dy0    <= edge_t'(r_x1 - r_x0);
            edge_dy1    <= edge_t'(r_x2 - r_x1);
            edge_dy2    <= edge_t'(r_x0 - r_x2);
            depth_start <= depth_t'(r_z + r_dzx * r_bx0 + r_dzy * r_by0);
            step_z_x    <= r_dzx;
            step_z_y    <= r_dzy;
        end
    end

    // One triangle per start, so results never come back to back.
    a_setup_single: assert property (@(posedge clk) disable iff (!rstn)
        setup_valid |=> !setup_valid);

endmodule

`default_nettype wire

//--- src/raster_walker.sv
`default_nettype none

module raster_walker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                setup_valid,
    input  logic                empty,
    input  raster_pkg::coord_t  box_x0,
    input  raster_pkg::coord_t  box_y0,
    input  raster_pkg::coord_t  box_x1,
    input  raster_pkg::coord_t  box_y1,
    input  raster_pkg::edge_t   edge0,
    input  raster_pkg::edge_t   edge1,
    input  raster_pkg::edge_t   edge2,
    input  raster_pkg::edge_t   edge_dx0,
    input  raster_pkg::edge_t   edge_dx1,
    input  raster_pkg::edge_t   edge_dx2,
    input  raster_pkg::edge_t   edge_dy0,
    input  raster_pkg::edge_t   edge_dy1,
    input  raster_pkg::edge_t   edge_dy2,
    input  raster_pkg::depth_t  depth_start,
    input  raster_pkg::depth_t  step_z_x,
    input  raster_pkg::depth_t  step_z_y,
    output logic                frag_valid,
    output logic                frag_last,
    output raster_pkg::addr_t   frag_addr,
    output raster_pkg::depth_t  frag_depth,
    output logic                frag_inside
);

    import raster_pkg::*;

    walk_state_t state, state_next;

    coord_t r_x, r_y;
    edge_t  r_e0, r_e1, r_e2;
    edge_t  r_row_e0, r_row_e1, r_row_e2;
    depth_t r_z, r_row_z;
    addr_t  r_addr;
    addr_t  r_line_jump;

    logic   row_end;
    logic   box_end;

    assign row_end = (r_x == box_x1);
    assign box_end = row_end && (r_y == box_y1);

    assign frag_valid  = (state == scan);
    assign frag_last   = ((state == scan) && box_end) || ((state == load) && empty);
    assign frag_addr   = r_addr;
    assign frag_depth  = r_z;
    assign frag_inside = (r_e0 > 0) && (r_e1 > 0) && (r_e2 > 0);

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (setup_valid) begin
                    state_next = load;
                end
            end
            load: begin
                state_next = empty ? finish : scan;
            end
            scan: begin
                if (box_end) begin
                    state_next = finish;
                end
            end
            finish: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Incremental walk, no multiplies per pixel.
    always_ff @(posedge clk) begin
        if (state == load) begin
            r_x         <= box_x0;
            r_y         <= box_y0;
            r_e0        <= edge0;
            r_e1        <= edge1;
            r_e2        <= edge2;
            r_row_e0    <= edge0;
            r_row_e1    <= edge1;
            r_row_e2    <= edge2;
            r_z         <= depth_start;
            r_row_z     <= depth_start;
            r_addr      <= addr_t'(box_y0 * screen_w + box_x0);
            r_line_jump <= addr_t'(screen_w - (box_x1 - box_x0));
        end else if (state == scan) begin
            if (!row_end) begin
                r_x    <= r_x + coord_t'(1);
                r_e0   <= r_e0 + edge_dx0;
                r_e1   <= r_e1 + edge_dx1;
                r_e2   <= r_e2 + edge_dx2;
                r_z    <= r_z + step_z_x;
                r_addr <= r_addr + addr_t'(1);
            end else begin
                // Back to the left column of the next row.
                r_x      <= box_x0;
                r_y      <= r_y + coord_t'(1);
                r_e0     <= r_row_e0 + edge_dy0;
                r_e1     <= r_row_e1 + edge_dy1;
                r_e2     <= r_row_e2 + edge_dy2;
                r_row_e0 <= r_row_e0 + edge_dy0;
                r_row_e1 <= r_row_e1 + edge_dy1;
                r_row_e2 <= r_row_e2 + edge_dy2;
                r_z      <= r_row_z + step_z_y;
                r_row_z  <= r_row_z + step_z_y;
                r_addr   <= r_addr + r_line_jump;
            end
        end
    end

    // The stepped address tracks the scan position on screen.
    a_addr_on_screen: assert property (@(posedge clk) disable iff (!rstn)
        frag_valid |-> (int'(r_y) * screen_w + int'(r_x) == int'(frag_addr))
                    && (int'(r_y) * screen_w + int'(r_x) < pix_count));

    a_last_finishes: assert property (@(posedge clk) disable iff (!rstn)
        frag_last |=> (state == finish));

endmodule

`default_nettype wire

//--- src/depth_frame_buffer.sv
`default_nettype none

module depth_frame_buffer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  logic                clear,
    input  logic                frag_valid,
    input  logic                frag_last,
    input  raster_pkg::addr_t   frag_addr,
    input  raster_pkg::depth_t  frag_depth,
    input  logic                frag_inside,
    input  raster_pkg::color_t  color,
    input  raster_pkg::addr_t   rd_addr,
    output logic                busy,
    output logic                done,
    output raster_pkg::color_t  rd_color,
    output raster_pkg::depth_t  rd_depth
);

    import raster_pkg::*;

    depth_t depth_mem [pix_count];
    color_t color_mem [pix_count];

    logic   clearing;
    logic   clr_tail;
    addr_t  clr_addr;
    color_t cur_color;

    // Fragment pipeline, one stage after the read.
    logic   p_valid;
    logic   p_last;
    addr_t  p_addr;
    depth_t p_depth;
    depth_t old_depth;

    logic   we;
    addr_t  wr_addr;
    depth_t wr_depth;
    color_t wr_color;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            clearing <= 1'b0;
            clr_tail <= 1'b0;
            clr_addr <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                end else if (clear) begin
                    busy     <= 1'b1;
                    clearing <= 1'b1;
                    clr_addr <= '0;
                end
            end else begin
                if (clearing) begin
                    clr_addr <= clr_addr + addr_t'(1);
                    if (clr_addr == addr_t'(pix_count - 1)) begin
                        clearing <= 1'b0;
                        clr_tail <= 1'b1;
                    end
                end
                if (clr_tail || p_last) begin
                    clr_tail <= 1'b0;
                    busy     <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

    // Flat shading, one color per triangle.
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            cur_color <= color;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            p_valid <= 1'b0;
            p_last  <= 1'b0;
        end else begin
            p_valid <= frag_valid && frag_inside;
            p_last  <= frag_last;
        end
    end

    always_ff @(posedge clk) begin
        p_addr    <= frag_addr;
        p_depth   <= frag_depth;
        old_depth <= depth_mem[frag_addr];
    end

    // Clear owns the write port while it runs.
    always_comb begin
        we       = 1'b0;
        wr_addr  = p_addr;
        wr_depth = p_depth;
        wr_color = cur_color;
        if (clearing) begin
            we       = 1'b1;
            wr_addr  = clr_addr;
            wr_depth = depth_far;
            wr_color = '0;
        end else if (p_valid && (p_depth < old_depth)) begin
            we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            depth_mem[wr_addr] <= wr_depth;
            color_mem[wr_addr] <= wr_color;
        end
    end

    // Host read-back.
    always_ff @(posedge clk) begin
        rd_color <= color_mem[rd_addr];
        rd_depth <= depth_mem[rd_addr];
    end

    a_no_frag_in_clear: assert property (@(posedge clk) disable iff (!rstn)
        clearing |-> !frag_valid);

endmodule

`default_nettype wire

//--- src/rasterizer_top.sv
`default_nettype none

module rasterizer_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  logic                clear,
    input  raster_pkg::coord_t  x0,
    input  raster_pkg::coord_t  y0,
    input  raster_pkg::coord_t  x1,
    input  raster_pkg::coord_t  y1,
    input  raster_pkg::coord_t  x2,
    input  raster_pkg::coord_t  y2,
    input  raster_pkg::depth_t  z,
    input  raster_pkg::depth_t  dz_dx,
    input  raster_pkg::depth_t  dz_dy,
    input  raster_pkg::color_t  color,
    input  raster_pkg::addr_t   rd_addr,
    output logic                busy,
    output logic                done,
    output raster_pkg::color_t  rd_color,
    output raster_pkg::depth_t  rd_depth
);

    import raster_pkg::*;

    logic   start_ok;
    logic   setup_valid;
    logic   empty;
    coord_t box_x0, box_y0, box_x1, box_y1;
    edge_t  edge0, edge1, edge2;
    edge_t  edge_dx0, edge_dx1, edge_dx2;
    edge_t  edge_dy0, edge_dy1, edge_dy2;
    depth_t depth_start, step_z_x, step_z_y;

    logic   frag_valid;
    logic   frag_last;
    addr_t  frag_addr;
    depth_t frag_depth;
    logic   frag_inside;

    // Starts while busy are dropped.
    assign start_ok = start && !busy;

    triangle_setup i_triangle_setup (
        .clk, .rstn, .start(start_ok),
        .x0, .y0, .x1, .y1, .x2, .y2, .z, .dz_dx, .dz_dy,
        .setup_valid, .empty, .box_x0, .box_y0, .box_x1, .box_y1,
        .edge0, .edge1, .edge2, .edge_dx0, .edge_dx1, .edge_dx2,
        .edge_dy0, .edge_dy1, .edge_dy2, .depth_start, .step_z_x, .step_z_y
    );

    raster_walker i_raster_walker (
        .clk, .rstn, .setup_valid, .empty, .box_x0, .box_y0, .box_x1, .box_y1,
        .edge0, .edge1, .edge2, .edge_dx0, .edge_dx1, .edge_dx2,
        .edge_dy0, .edge_dy1, .edge_dy2, .depth_start, .step_z_x, .step_z_y,
        .frag_valid, .frag_last, .frag_addr, .frag_depth, .frag_inside
    );

    depth_frame_buffer i_depth_frame_buffer (
        .clk, .rstn, .start, .clear,
        .frag_valid, .frag_last, .frag_addr, .frag_depth, .frag_inside,
        .color, .rd_addr, .busy, .done, .rd_color, .rd_depth
    );

endmodule

`default_nettype wire

//--- test/rasterizer_tb.sv
`default_nettype none

module rasterizer_tb;

    import raster_pkg::*;

    typedef struct packed {
        logic       is_clear;
        logic       poke;
        int         x0;
        int         y0;
        int         x1;
        int         y1;
        int         x2;
        int         y2;
        int         z;
        int         dzx;
        int         dzy;
        logic [7:0] color;
        int         exp_count;
    } op_t;

    logic   clk;
    logic   rstn;
    logic   start;
    logic   clear;
    coord_t x0, y0, x1, y1, x2, y2;
    depth_t z, dz_dx, dz_dy;
    color_t color;
    addr_t  rd_addr;
    logic   busy;
    logic   done;
    color_t rd_color;
    depth_t rd_depth;

    op_t   ops[$];
    string op_names[$];

    // Reference image, updated by the plane, edge and box rules.
    logic signed [15:0] model_depth [256];
    logic [7:0]         model_color [256];

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;
    int cycle_limit = 0;

    rasterizer_top i_rasterizer_top (
        .clk, .rstn, .start, .clear,
        .x0, .y0, .x1, .y1, .x2, .y2, .z, .dz_dx, .dz_dy, .color,
        .rd_addr, .busy, .done, .rd_color, .rd_depth
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic op_t make_tri(input int ax, input int ay, input int bx, input int by,
                                     input int cx, input int cy, input int z0, input int zx,
                                     input int zy, input logic [7:0] col, input logic poke,
                                     input int count);
        op_t o;
        o.is_clear  = 1'b0;
        o.poke      = poke;
        o.x0        = ax;
        o.y0        = ay;
        o.x1        = bx;
        o.y1        = by;
        o.x2        = cx;
        o.y2        = cy;
        o.z         = z0;
        o.dzx       = zx;
        o.dzy       = zy;
        o.color     = col;
        o.exp_count = count;
        return o;
    endfunction

    function automatic op_t make_clear();
        op_t o;
        o = make_tri(0, 0, 0, 0, 0, 0, 0, 0, 0, 8'h00, 1'b0, 0);
        o.is_clear = 1'b1;
        return o;
    endfunction

    // Counts are the pixels that show the triangle's color once it is drawn.
    task automatic build_table();
        ops.push_back(make_clear());
        op_names.push_back("clear");
        ops.push_back(make_tri(0, 0, 10, 0, 0, 10, 100, 1, 1, 8'h11, 1'b0, 36));
        op_names.push_back("first triangle");
        ops.push_back(make_tri(2, 2, 14, 2, 2, 14, 50, 0, 0, 8'h22, 1'b0, 55));
        op_names.push_back("nearer overlap");
        ops.push_back(make_tri(0, 0, 15, 0, 0, 15, 1000, 0, 0, 8'h33, 1'b0, 20));
        op_names.push_back("farther overlap");
        ops.push_back(make_tri(4, 4, 12, 4, 4, 12, 10, 0, 1, 8'h55, 1'b1, 21));
        op_names.push_back("start while busy");
        ops.push_back(make_clear());
        op_names.push_back("clear again");
        ops.push_back(make_tri(-10, -10, 30, -10, -10, 30, -5, 2, -3, 8'h44, 1'b0, 190));
        op_names.push_back("clamped vertices");
        ops.push_back(make_tri(0, 0, 0, 10, 10, 0, -1000, 0, 0, 8'h77, 1'b0, 0));
        op_names.push_back("reverse winding");
        ops.push_back(make_tri(1, 1, 5, 5, 9, 9, -1000, 0, 0, 8'h78, 1'b0, 0));
        op_names.push_back("degenerate");
        ops.push_back(make_tri(20, 20, 30, 20, 20, 30, -1000, 0, 0, 8'h79, 1'b0, 0));
        op_names.push_back("off screen low right");
        ops.push_back(make_tri(-30, -30, -20, -30, -30, -20, -1000, 0, 0, 8'h7a, 1'b0, 0));
        op_names.push_back("off screen top left");
    endtask

    task automatic drive_op(input op_t o);
        x0    = coord_t'(o.x0);
        y0    = coord_t'(o.y0);
        x1    = coord_t'(o.x1);
        y1    = coord_t'(o.y1);
        x2    = coord_t'(o.x2);
        y2    = coord_t'(o.y2);
        z     = depth_t'(o.z);
        dz_dx = depth_t'(o.dzx);
        dz_dy = depth_t'(o.dzy);
        color = o.color;
    endtask

    function automatic int edge_fn(input int xa, input int ya, input int xb, input int yb,
                                   input int px, input int py);
        return (xb - xa) * (py - ya) - (yb - ya) * (px - xa);
    endfunction

    function automatic int smallest(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic int largest(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    function automatic int to_screen(input int v, input int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    task automatic model_clear();
        int a;
        for (a = 0; a < pix_count; a++) begin
            model_depth[a] = 16'sh7fff;
            model_color[a] = 8'h00;
        end
    endtask

    task automatic draw_model(input op_t o);
        int bx0, by0, bx1, by1;
        int x, y, a;
        logic signed [15:0] d;
        bx0 = to_screen(smallest(o.x0, o.x1, o.x2), screen_w - 1);
        bx1 = to_screen(largest(o.x0, o.x1, o.x2), screen_w - 1);
        by0 = to_screen(smallest(o.y0, o.y1, o.y2), screen_h - 1);
        by1 = to_screen(largest(o.y0, o.y1, o.y2), screen_h - 1);
        for (y = by0; y <= by1; y++) begin
            for (x = bx0; x <= bx1; x++) begin
                if (edge_fn(o.x0, o.y0, o.x1, o.y1, x, y) > 0 &&
                    edge_fn(o.x1, o.y1, o.x2, o.y2, x, y) > 0 &&
                    edge_fn(o.x2, o.y2, o.x0, o.y0, x, y) > 0) begin
                    a = y * screen_w + x;
                    // Plane depth wraps to 16 bits.
                    d = 16'(o.z + o.dzx * x + o.dzy * y);
                    if (d < model_depth[a]) begin
                        model_depth[a] = d;
                        model_color[a] = o.color;
                    end
                end
            end
        end
    endtask

    task automatic run_op(input op_t o, input int id, output int busy_cycles);
        int n;
        logic seen;
        drive_op(o);
        if (o.is_clear) begin
            clear = 1'b1;
        end else begin
            start = 1'b1;
        end
        @(negedge clk);
        start = 1'b0;
        clear = 1'b0;
        check_value("busy", 32'd1, 32'(busy));
        busy_cycles = 1;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 600) begin
            if (o.poke && n == 3) begin
                // A full-screen triangle that must not be drawn.
                drive_op(make_tri(0, 0, 15, 0, 0, 15, -100, 0, 0, 8'h66, 1'b0, 0));
                start = 1'b1;
            end
            @(negedge clk);
            if (start) begin
                start = 1'b0;
                drive_op(o);
            end
            n++;
            if (done) begin
                seen = 1'b1;
            end else begin
                check_value("busy", 32'd1, 32'(busy));
                busy_cycles++;
            end
        end
        if (!seen) begin
            $display("Operation %0d never pulsed done within 600 cycles", id);
            errors++;
        end
    endtask

    // Read port has one cycle of latency, so reads overlap with checks.
    task automatic read_screen(input color_t col, output int lit);
        int a;
        lit = 0;
        rd_addr = '0;
        @(negedge clk);
        for (a = 0; a < pix_count; a++) begin
            check_value($sformatf("rd_depth[%0d]", a), {16'h0, model_depth[a]},
                        {16'h0, rd_depth});
            check_value($sformatf("rd_color[%0d]", a), {24'h0, model_color[a]},
                        {24'h0, rd_color});
            if (rd_color === col) begin
                lit++;
            end
            rd_addr = addr_t'(a + 1);
            @(negedge clk);
        end
    endtask

    initial begin
        int i;
        int busy_cycles;
        int lit;
        int errors_before;
        clk     = 1'b0;
        rstn    = 1'b0;
        start   = 1'b0;
        clear   = 1'b0;
        rd_addr = '0;
        drive_op(make_clear());
        build_table();
        cycle_limit = ops.size() * 600 + ops.size() * 300 + 100;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (i = 0; i < ops.size(); i++) begin
            errors_before = errors;
            run_op(ops[i], i, busy_cycles);
            if (ops[i].is_clear) begin
                model_clear();
                check_value("clear busy cycles", 32'(pix_count + 1), busy_cycles);
            end else begin
                draw_model(ops[i]);
            end
            read_screen(ops[i].color, lit);
            if (!ops[i].is_clear) begin
                check_value("lit pixels", ops[i].exp_count, lit);
            end
            if (errors == errors_before) begin
                tests_passed++;
                $display("test %0d %s: ok", i, op_names[i]);
            end else begin
                tests_failed++;
                $display("test %0d %s: %0d errors", i, op_names[i], errors - errors_before);
            end
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rasterizer.f
src/raster_pkg.sv
src/triangle_setup.sv
src/raster_walker.sv
src/depth_frame_buffer.sv
src/rasterizer_top.sv
test/rasterizer_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module rasterizer_tb \
    -f rasterizer.f

./obj_dir/Vrasterizer_tb > sim.log 2>&1 || {
    cat sim.log
    exit 1
}
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
